//--- design/axis_switch_defs.svh
`ifndef AXIS_SWITCH_DEFS_SVH
`define AXIS_SWITCH_DEFS_SVH

// stream beat field widths
`define AXIS_DATA_W 32
`define AXIS_KEEP_W (`AXIS_DATA_W / 8)
`define AXIS_USER_W 2
`define AXIS_TID_W 2

// beats a normal grant may hold the serdes link
`define ARB_BURST_MAX 8

// downstream buffering
`define DS_FIFO_DEPTH 16

`endif

//--- design/axis_beat_pkg.sv
`include "axis_switch_defs.svh"

package axis_beat_pkg;

    // payload of one beat
    typedef logic [`AXIS_DATA_W-1:0] axis_data_t;

    // one enable bit per data byte
    typedef logic [`AXIS_KEEP_W-1:0] axis_keep_t;

    // user sideband carried with each beat
    typedef logic [`AXIS_USER_W-1:0] axis_user_t;

    // source id upstream and destination id downstream
    typedef logic [`AXIS_TID_W-1:0] axis_tid_t;

endpackage

//--- design/axis_arb_pkg.sv
`include "axis_switch_defs.svh"

package axis_arb_pkg;

    // upstream source numbers, also used as tid
    typedef logic [`AXIS_TID_W-1:0] src_id_t;

    localparam src_id_t SRC_UP = 2'd0;
    localparam src_id_t SRC_AA = 2'd1;
    localparam src_id_t SRC_LA = 2'd2;

    // wait states remember the last source served
    typedef enum logic [2:0] {
        WAIT_UP, WAIT_AA, WAIT_LA,
        GRANT_UP, GRANT_AA, GRANT_LA
    } arb_state_t;

    typedef logic [$clog2(`ARB_BURST_MAX)-1:0] burst_cnt_t;

endpackage

//--- design/axis_beat_if.sv
`timescale 1ns/1ns

interface axis_beat_if
    import axis_beat_pkg::*;
();
    logic       tvalid;
    logic       tready;
    axis_data_t tdata;
    axis_keep_t tkeep;
    logic       tlast;
    axis_user_t tuser;
    axis_tid_t  tid;

    // driver side of the link
    modport source (
        output tvalid, tdata, tkeep, tlast, tuser, tid,
        input  tready
    );

    modport sink (
        input  tvalid, tdata, tkeep, tlast, tuser, tid,
        output tready
    );
endinterface

//--- design/upstream_arbiter.sv
`timescale 1ns/1ns
`include "axis_switch_defs.svh"

module upstream_arbiter
    import axis_arb_pkg::*;
(
    input logic         axis_clk,
    input logic         axi_reset_n,
    input logic         up_hpri_req,
    input logic         la_hpri_req,
    axis_beat_if.sink   up_src,
    axis_beat_if.sink   aa_src,
    axis_beat_if.sink   la_src,
    axis_beat_if.source is_out
);
    localparam burst_cnt_t BURST_LAST = burst_cnt_t'(`ARB_BURST_MAX - 1);

    arb_state_t state;
    arb_state_t state_nxt;
    burst_cnt_t burst_cnt;
    src_id_t    cur_src;
    logic       granted;
    logic       normal_grant;
    logic       xfer;
    logic       burst_end;
    logic [2:0] hreq;
    logic [2:0] nreq;

    function automatic arb_state_t wait_of(input src_id_t src);
        case (src)
            SRC_AA:  return WAIT_AA;
            SRC_LA:  return WAIT_LA;
            default: return WAIT_UP;
        endcase
    endfunction

    function automatic arb_state_t grant_of(input src_id_t src);
        case (src)
            SRC_AA:  return GRANT_AA;
            SRC_LA:  return GRANT_LA;
            default: return GRANT_UP;
        endcase
    endfunction

    // round robin from the source after last_src with hpri over normal
    function automatic arb_state_t pick_next(input src_id_t last_src,
                                             input logic [2:0] hreq_v,
                                             input logic [2:0] nreq_v);
        arb_state_t nxt;
        int         idx;
        nxt = wait_of(last_src);
        // weakest candidates first so the strongest match is assigned last
        for (int i = 3; i >= 1; i--) begin
            idx = (int'(last_src) + i) % 3;
            if (nreq_v[idx]) nxt = grant_of(src_id_t'(idx));
        end
        for (int i = 3; i >= 1; i--) begin
            idx = (int'(last_src) + i) % 3;
            if (hreq_v[idx]) nxt = grant_of(src_id_t'(idx));
        end
        return nxt;
    endfunction

    // aa has no high-priority request
    assign hreq = {la_hpri_req, 1'b0, up_hpri_req};
    assign nreq = {la_src.tvalid, aa_src.tvalid, up_src.tvalid};

    always_comb begin
        granted = 1'b0;
        cur_src = SRC_UP;
        case (state)
            WAIT_AA:  cur_src = SRC_AA;
            WAIT_LA:  cur_src = SRC_LA;
            GRANT_UP: granted = 1'b1;
            GRANT_AA: begin
                granted = 1'b1;
                cur_src = SRC_AA;
            end
            GRANT_LA: begin
                granted = 1'b1;
                cur_src = SRC_LA;
            end
            default: ;
        endcase
    end

    assign normal_grant = granted && !hreq[cur_src];
    assign xfer = is_out.tvalid && is_out.tready;
    assign burst_end = xfer && (is_out.tlast || (normal_grant && burst_cnt == BURST_LAST));

    always_comb begin
        if (granted) begin
            state_nxt = burst_end ? wait_of(cur_src) : state;
        end else begin
            state_nxt = pick_next(cur_src, hreq, nreq);
        end
    end

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            state     <= WAIT_UP;
            burst_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (!normal_grant) begin
                burst_cnt <= '0;
            end else if (xfer) begin
                burst_cnt <= burst_cnt + 1'b1;
            end
        end
    end

    // granted beat straight through to the serdes
    always_comb begin
        is_out.tvalid = 1'b0;
        is_out.tdata  = '0;
        is_out.tkeep  = '0;
        is_out.tlast  = 1'b0;
        is_out.tuser  = '0;
        is_out.tid    = '0;
        up_src.tready = 1'b0;
        aa_src.tready = 1'b0;
        la_src.tready = 1'b0;
        if (granted) begin
            is_out.tid = cur_src;
            case (cur_src)
                SRC_AA: begin
                    is_out.tvalid = aa_src.tvalid;
                    is_out.tdata  = aa_src.tdata;
                    is_out.tkeep  = aa_src.tkeep;
                    is_out.tlast  = aa_src.tlast;
                    is_out.tuser  = aa_src.tuser;
                    aa_src.tready = is_out.tready;
                end
                SRC_LA: begin
                    is_out.tvalid = la_src.tvalid;
                    is_out.tdata  = la_src.tdata;
                    is_out.tkeep  = la_src.tkeep;
                    is_out.tlast  = la_src.tlast;
                    is_out.tuser  = la_src.tuser;
                    la_src.tready = is_out.tready;
                end
                default: begin
                    is_out.tvalid = up_src.tvalid;
                    is_out.tdata  = up_src.tdata;
                    is_out.tkeep  = up_src.tkeep;
                    is_out.tlast  = up_src.tlast;
                    is_out.tuser  = up_src.tuser;
                    up_src.tready = is_out.tready;
                end
            endcase
        end
    end
endmodule

//--- design/downstream_fifo.sv
`timescale 1ns/1ns
`include "axis_switch_defs.svh"

module downstream_fifo
    import axis_beat_pkg::*;
#(
    parameter int DEPTH = `DS_FIFO_DEPTH
) (
    input logic         axis_clk,
    input logic         axi_reset_n,
    axis_beat_if.sink   in,
    axis_beat_if.source out
);
    localparam int AW = $clog2(DEPTH);

    // beat storage split by field
    axis_data_t data_mem [DEPTH];
    axis_keep_t keep_mem [DEPTH];
    axis_user_t user_mem [DEPTH];
    axis_tid_t  tid_mem  [DEPTH];
    logic       last_mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    assign in.tready  = (count != (AW + 1)'(DEPTH));
    assign out.tvalid = (count != '0);
    assign push = in.tvalid && in.tready;
    assign pop  = out.tvalid && out.tready;

    always_ff @(posedge axis_clk) begin
        if (push) begin
            data_mem[wr_ptr] <= in.tdata;
            keep_mem[wr_ptr] <= in.tkeep;
            user_mem[wr_ptr] <= in.tuser;
            tid_mem[wr_ptr]  <= in.tid;
            last_mem[wr_ptr] <= in.tlast;
        end
    end

    // pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // head of queue
    assign out.tdata = data_mem[rd_ptr];
    assign out.tkeep = keep_mem[rd_ptr];
    assign out.tuser = user_mem[rd_ptr];
    assign out.tid   = tid_mem[rd_ptr];
    assign out.tlast = last_mem[rd_ptr];
endmodule

//--- design/downstream_demux.sv
`timescale 1ns/1ns

module downstream_demux
    import axis_arb_pkg::*;
(
    axis_beat_if.sink   in,
    axis_beat_if.source up_dst,
    axis_beat_if.source aa_dst
);
    logic to_up;
    logic to_aa;

    assign to_up = (in.tid == SRC_UP);
    assign to_aa = (in.tid == SRC_AA);

    // only the addressed port sees the beat
    assign up_dst.tvalid = in.tvalid && to_up;
    assign up_dst.tdata  = to_up ? in.tdata : '0;
    assign up_dst.tkeep  = to_up ? in.tkeep : '0;
    assign up_dst.tlast  = to_up && in.tlast;
    assign up_dst.tuser  = to_up ? in.tuser : '0;
    assign up_dst.tid    = to_up ? in.tid : '0;

    assign aa_dst.tvalid = in.tvalid && to_aa;
    assign aa_dst.tdata  = to_aa ? in.tdata : '0;
    assign aa_dst.tkeep  = to_aa ? in.tkeep : '0;
    assign aa_dst.tlast  = to_aa && in.tlast;
    assign aa_dst.tuser  = to_aa ? in.tuser : '0;
    assign aa_dst.tid    = to_aa ? in.tid : '0;

    // tid 2 and 3 have no consumer and are dropped
    assign in.tready = to_up ? up_dst.tready : (to_aa ? aa_dst.tready : 1'b1);
endmodule

//--- design/axis_switch.sv
`timescale 1ns/1ns

module axis_switch
    import axis_beat_pkg::*;
(
    input  logic       axis_clk,
    input  logic       axi_reset_n,
    // user project source
    input  axis_data_t up_as_tdata,
    input  axis_keep_t up_as_tkeep,
    input  logic       up_as_tlast,
    input  logic       up_as_tvalid,
    input  axis_user_t up_as_tuser,
    input  logic       up_hpri_req,
    output logic       as_up_tready,
    // register bridge source
    input  axis_data_t aa_as_tdata,
    input  axis_keep_t aa_as_tkeep,
    input  logic       aa_as_tlast,
    input  logic       aa_as_tvalid,
    input  axis_user_t aa_as_tuser,
    output logic       as_aa_tready,
    // logic analyzer source
    input  axis_data_t la_as_tdata,
    input  axis_keep_t la_as_tkeep,
    input  logic       la_as_tlast,
    input  logic       la_as_tvalid,
    input  axis_user_t la_as_tuser,
    input  logic       la_hpri_req,
    output logic       as_la_tready,
    // upstream to serdes
    output axis_data_t as_is_tdata,
    output axis_keep_t as_is_tkeep,
    output logic       as_is_tlast,
    output logic       as_is_tvalid,
    output axis_user_t as_is_tuser,
    output axis_tid_t  as_is_tid,
    input  logic       is_as_tready,
    // downstream from serdes
    input  axis_data_t is_as_tdata,
    input  axis_keep_t is_as_tkeep,
    input  logic       is_as_tlast,
    input  logic       is_as_tvalid,
    input  axis_user_t is_as_tuser,
    input  axis_tid_t  is_as_tid,
    output logic       as_is_tready,
    // downstream to user project
    output axis_data_t as_up_tdata,
    output axis_keep_t as_up_tkeep,
    output logic       as_up_tlast,
    output logic       as_up_tvalid,
    output axis_user_t as_up_tuser,
    input  logic       up_as_tready,
    // downstream to register bridge
    output axis_data_t as_aa_tdata,
    output axis_keep_t as_aa_tkeep,
    output logic       as_aa_tlast,
    output logic       as_aa_tvalid,
    output axis_user_t as_aa_tuser,
    input  logic       aa_as_tready
);
    axis_beat_if up_src ();
    axis_beat_if aa_src ();
    axis_beat_if la_src ();
    axis_beat_if is_out ();
    axis_beat_if is_in ();
    axis_beat_if fifo_out ();
    axis_beat_if up_dst ();
    axis_beat_if aa_dst ();

    // source tid is replaced by the arbiter
    assign {up_src.tvalid, up_src.tdata, up_src.tkeep, up_src.tlast, up_src.tuser} =
        {up_as_tvalid, up_as_tdata, up_as_tkeep, up_as_tlast, up_as_tuser};
    assign up_src.tid = '0;
    assign as_up_tready = up_src.tready;

    assign {aa_src.tvalid, aa_src.tdata, aa_src.tkeep, aa_src.tlast, aa_src.tuser} =
        {aa_as_tvalid, aa_as_tdata, aa_as_tkeep, aa_as_tlast, aa_as_tuser};
    assign aa_src.tid = '0;
    assign as_aa_tready = aa_src.tready;

    assign {la_src.tvalid, la_src.tdata, la_src.tkeep, la_src.tlast, la_src.tuser} =
        {la_as_tvalid, la_as_tdata, la_as_tkeep, la_as_tlast, la_as_tuser};
    assign la_src.tid = '0;
    assign as_la_tready = la_src.tready;

    assign {as_is_tvalid, as_is_tdata, as_is_tkeep, as_is_tlast, as_is_tuser, as_is_tid} =
        {is_out.tvalid, is_out.tdata, is_out.tkeep, is_out.tlast, is_out.tuser, is_out.tid};
    assign is_out.tready = is_as_tready;

    assign {is_in.tvalid, is_in.tdata, is_in.tkeep, is_in.tlast, is_in.tuser, is_in.tid} =
        {is_as_tvalid, is_as_tdata, is_as_tkeep, is_as_tlast, is_as_tuser, is_as_tid};
    assign as_is_tready = is_in.tready;

    // destination tid is implied by the port
    assign {as_up_tvalid, as_up_tdata, as_up_tkeep, as_up_tlast, as_up_tuser} =
        {up_dst.tvalid, up_dst.tdata, up_dst.tkeep, up_dst.tlast, up_dst.tuser};
    assign up_dst.tready = up_as_tready;

    assign {as_aa_tvalid, as_aa_tdata, as_aa_tkeep, as_aa_tlast, as_aa_tuser} =
        {aa_dst.tvalid, aa_dst.tdata, aa_dst.tkeep, aa_dst.tlast, aa_dst.tuser};
    assign aa_dst.tready = aa_as_tready;

    upstream_arbiter i_upstream_arbiter (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .up_hpri_req (up_hpri_req),
        .la_hpri_req (la_hpri_req),
        .up_src      (up_src.sink),
        .aa_src      (aa_src.sink),
        .la_src      (la_src.sink),
        .is_out      (is_out.source)
    );

    downstream_fifo i_downstream_fifo (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .in          (is_in.sink),
        .out         (fifo_out.source)
    );

    downstream_demux i_downstream_demux (
        .in     (fifo_out.sink),
        .up_dst (up_dst.source),
        .aa_dst (aa_dst.source)
    );
endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 4
) (
    output logic axis_clk
);
    // free-running clock from time zero
    initial begin
        axis_clk = 1'b0;
        forever #(PERIOD / 2) axis_clk = ~axis_clk;
    end
endmodule

//--- bench/axis_switch_sva.sv
`timescale 1ns/1ns

module axis_switch_sva
    import axis_beat_pkg::*;
(
    input logic       axis_clk,
    input logic       axi_reset_n,
    input logic       as_up_tready,
    input logic       as_aa_tready,
    input logic       as_la_tready,
    input logic       as_is_tvalid,
    input axis_data_t as_is_tdata,
    input axis_keep_t as_is_tkeep,
    input logic       as_is_tlast,
    input axis_user_t as_is_tuser,
    input axis_tid_t  as_is_tid,
    input logic       is_as_tready,
    input logic       as_up_tvalid,
    input logic       as_aa_tvalid
);
    // only the granted source sees tready
    a_one_ready: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        $onehot0({as_up_tready, as_aa_tready, as_la_tready}))
        else $error("more than one source tready is high");

    a_reset_idle: assert property (@(posedge axis_clk) !axi_reset_n |-> !as_is_tvalid)
        else $error("as_is_tvalid high during reset");

    // a stalled upstream beat must hold
    a_hold_beat: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        (as_is_tvalid && !is_as_tready) |=> (as_is_tvalid &&
        $stable({as_is_tdata, as_is_tkeep, as_is_tlast, as_is_tuser, as_is_tid})))
        else $error("upstream beat changed while stalled");

    a_one_dest: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        !(as_up_tvalid && as_aa_tvalid))
        else $error("as_up_tvalid and as_aa_tvalid high together");
endmodule

bind axis_switch axis_switch_sva i_sva (.*);

//--- bench/axis_switch_tb.sv
`timescale 1ns/1ns
`include "axis_switch_defs.svh"

module axis_switch_tb
    import axis_beat_pkg::*;
    import axis_arb_pkg::*;
();
    localparam int BEAT_W = `AXIS_DATA_W + `AXIS_KEEP_W + `AXIS_USER_W + 1;
    localparam int TIMEOUT = 500;
    typedef logic [BEAT_W-1:0] beat_t;

    logic axis_clk;
    logic axi_reset_n;
    axis_data_t up_as_tdata, aa_as_tdata, la_as_tdata, as_is_tdata, is_as_tdata;
    axis_data_t as_up_tdata, as_aa_tdata;
    axis_keep_t up_as_tkeep, aa_as_tkeep, la_as_tkeep, as_is_tkeep, is_as_tkeep;
    axis_keep_t as_up_tkeep, as_aa_tkeep;
    axis_user_t up_as_tuser, aa_as_tuser, la_as_tuser, as_is_tuser, is_as_tuser;
    axis_user_t as_up_tuser, as_aa_tuser;
    axis_tid_t  as_is_tid, is_as_tid;
    logic up_as_tlast, aa_as_tlast, la_as_tlast, as_is_tlast, is_as_tlast;
    logic as_up_tlast, as_aa_tlast;
    logic up_as_tvalid, aa_as_tvalid, la_as_tvalid, as_is_tvalid, is_as_tvalid;
    logic as_up_tvalid, as_aa_tvalid;
    logic as_up_tready, as_aa_tready, as_la_tready, as_is_tready;
    logic is_as_tready = 1'b1;
    logic up_as_tready = 1'b1;
    logic aa_as_tready = 1'b1;
    logic up_hpri_req, la_hpri_req;

    logic [2:0] hpri;
    logic [2:0] req;
    logic [2:0] src_rdy;
    // expected beats per upstream source and per downstream port
    beat_t exp_q [3][$];
    beat_t ds_q [2][$];
    int    grant_log[$];
    bit    busy = 1'b0;
    bit    new_grant = 1'b0;
    int    cur_src = 0;
    int    last_src = 0;
    int    burst_cnt = 0;
    bit    rand_ready = 1'b0;
    int    mismatch_cnt = 0;
    int    fail_cnt = 0;

    assign hpri = {la_hpri_req, 1'b0, up_hpri_req};
    assign req = {la_as_tvalid, aa_as_tvalid, up_as_tvalid};
    assign src_rdy = {as_la_tready, as_aa_tready, as_up_tready};

    tb_clock_gen i_clk_gen (.axis_clk(axis_clk));

    axis_switch i_dut (.*);

    // next grant from the last served source with hpri before tvalid
    function automatic int next_grant(input int last, input logic [2:0] hp,
                                      input logic [2:0] vl);
        int idx;
        for (int i = 1; i <= 3; i++) begin
            idx = (last + i) % 3;
            if (hp[idx]) return idx;
        end
        for (int i = 1; i <= 3; i++) begin
            idx = (last + i) % 3;
            if (vl[idx]) return idx;
        end
        return -1;
    endfunction

    function automatic beat_t rand_beat(input bit last);
        return {last, axis_user_t'($urandom), axis_keep_t'($urandom), axis_data_t'($urandom)};
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Mismatch at %0t ns: %s expected %0h actual %0h", $time, name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic drive_src(input int src, input logic vld, input beat_t beat);
        case (src)
            0: {up_as_tvalid, up_as_tlast, up_as_tuser, up_as_tkeep, up_as_tdata} = {vld, beat};
            1: {aa_as_tvalid, aa_as_tlast, aa_as_tuser, aa_as_tkeep, aa_as_tdata} = {vld, beat};
            default: {la_as_tvalid, la_as_tlast, la_as_tuser, la_as_tkeep, la_as_tdata} =
                {vld, beat};
        endcase
    endtask

    task automatic send_pkt(input int src, input int len, input bit use_hpri);
        beat_t beat;
        int    t;
        if (use_hpri && src == 2) la_hpri_req = 1'b1;
        if (use_hpri && src == 0) up_hpri_req = 1'b1;
        for (int b = 0; b < len; b++) begin
            beat = rand_beat(b == len - 1);
            exp_q[src].push_back(beat);
            drive_src(src, 1'b1, beat);
            t = 0;
            @(negedge axis_clk);
            while (!src_rdy[src] && t < TIMEOUT) begin
                @(negedge axis_clk);
                t++;
            end
            if (t == TIMEOUT) begin
                $display("source %0d beat %0d was never accepted", src, b);
                fail_cnt++;
                break;
            end
            @(posedge axis_clk);
            #1;
        end
        drive_src(src, 1'b0, '0);
        if (use_hpri) {la_hpri_req, up_hpri_req} = 2'b00;
    endtask

    // serdes side; every seventh beat carries tid 2 or 3 and must vanish
    task automatic ds_send(input int n);
        beat_t     beat;
        axis_tid_t tid;
        int        t;
        for (int b = 0; b < n; b++) begin
            beat = rand_beat($urandom % 4 == 0);
            tid = (b % 7 == 3) ? axis_tid_t'(2 + b % 2) : axis_tid_t'($urandom % 2);
            {is_as_tvalid, is_as_tid, is_as_tlast, is_as_tuser, is_as_tkeep, is_as_tdata} =
                {1'b1, tid, beat};
            if (tid < 2) ds_q[tid].push_back(beat);
            t = 0;
            @(negedge axis_clk);
            while (!as_is_tready && t < TIMEOUT) begin
                @(negedge axis_clk);
                t++;
            end
            if (t == TIMEOUT) begin
                $display("downstream beat %0d was never accepted", b);
                fail_cnt++;
                break;
            end
            @(posedge axis_clk);
            #1;
        end
        is_as_tvalid = 1'b0;
    endtask

    task automatic check_upstream();
        int    g;
        logic  normal;
        beat_t beat;
        check_val("source treadys", busy ? (3'(is_as_tready) << cur_src) : 3'b0, src_rdy);
        if (!busy) begin
            check_val("as_is_tvalid", 0, as_is_tvalid);
            g = next_grant(last_src, hpri, req);
            if (g >= 0) begin
                busy = 1'b1;
                cur_src = g;
                new_grant = 1'b1;
            end
        end else begin
            normal = !hpri[cur_src];
            check_val("as_is_tvalid", req[cur_src], as_is_tvalid);
            if (as_is_tvalid) check_val("as_is_tid", cur_src, as_is_tid);
            if (!normal) burst_cnt = 0;
            if (as_is_tvalid && is_as_tready) begin
                // grant order as seen on the serdes link
                if (new_grant) begin
                    grant_log.push_back(int'(as_is_tid));
                    new_grant = 1'b0;
                end
                if (exp_q[cur_src].size() == 0) begin
                    $display("upstream beat from source %0d that was never sent", cur_src);
                    fail_cnt++;
                end else begin
                    beat = exp_q[cur_src].pop_front();
                    check_val("as_is beat", beat,
                              {as_is_tlast, as_is_tuser, as_is_tkeep, as_is_tdata});
                end
                if (as_is_tlast || (normal && burst_cnt == `ARB_BURST_MAX - 1)) begin
                    busy = 1'b0;
                    last_src = cur_src;
                    burst_cnt = 0;
                end else if (normal) begin
                    burst_cnt++;
                end
            end
        end
    endtask

    task automatic ds_pop(input int d, input beat_t act);
        beat_t beat;
        if (ds_q[d].size() == 0) begin
            $display("unexpected downstream beat on port %0d at %0t ns", d, $time);
            fail_cnt++;
        end else begin
            beat = ds_q[d].pop_front();
            check_val(d == 0 ? "as_up beat" : "as_aa beat", beat, act);
        end
    endtask

    task automatic check_order(input string name, input int exp[$]);
        if (exp.size() != grant_log.size()) begin
            $display("Mismatch at %0t ns: %s grant count expected %0d actual %0d",
                     $time, name, exp.size(), grant_log.size());
            mismatch_cnt++;
        end else begin
            foreach (exp[i]) check_val(name, exp[i], grant_log[i]);
        end
        grant_log.delete();
    endtask

    // compare process samples mid-cycle where outputs are settled
    always @(negedge axis_clk) begin
        if (axi_reset_n) begin
            check_upstream();
            if (as_up_tvalid && up_as_tready)
                ds_pop(0, {as_up_tlast, as_up_tuser, as_up_tkeep, as_up_tdata});
            if (as_aa_tvalid && aa_as_tready)
                ds_pop(1, {as_aa_tlast, as_aa_tuser, as_aa_tkeep, as_aa_tdata});
        end
    end

    always @(posedge axis_clk) begin
        #1;
        is_as_tready = rand_ready ? ($urandom % 4 != 0) : 1'b1;
        up_as_tready = rand_ready ? 1'($urandom % 2) : 1'b1;
        aa_as_tready = rand_ready ? 1'($urandom % 2) : 1'b1;
    end

    initial begin
        int t;
        void'($urandom(43));
        axi_reset_n = 1'b0;
        {up_hpri_req, la_hpri_req, is_as_tvalid, is_as_tid} = '0;
        {is_as_tdata, is_as_tkeep, is_as_tlast, is_as_tuser} = '0;
        for (int s = 0; s < 3; s++) drive_src(s, 1'b0, '0);
        repeat (5) @(posedge axis_clk);
        #1;
        axi_reset_n = 1'b1;
        @(negedge axis_clk);
        check_val("as_is_tvalid", 0, as_is_tvalid);
        check_val("as_up_tvalid", 0, as_up_tvalid);
        check_val("as_aa_tvalid", 0, as_aa_tvalid);
        check_val("as_is_tready", 1, as_is_tready);
        @(posedge axis_clk);
        #1;
        send_pkt(0, 5, 1'b0);
        check_order("single up grant", {0});
        fork
            begin send_pkt(1, 3, 1'b0); send_pkt(1, 3, 1'b0); end
            begin send_pkt(2, 3, 1'b0); send_pkt(2, 3, 1'b0); end
            begin send_pkt(0, 3, 1'b0); send_pkt(0, 3, 1'b0); end
        join
        check_order("round robin", {1, 2, 0, 1, 2, 0});
        // la holds 12 beats through the burst limit
        fork
            send_pkt(0, 4, 1'b0);
            send_pkt(1, 4, 1'b0);
            send_pkt(2, 12, 1'b1);
        join
        check_order("hpri grant", {2, 0, 1});
        rand_ready = 1'b1;
        fork
            send_pkt(1, 20, 1'b0);
            begin send_pkt(2, 3, 1'b0); send_pkt(2, 3, 1'b0); end
        join
        check_order("burst limit", {2, 1, 2, 1, 1});
        ds_send(60);
        t = 0;
        while ((ds_q[0].size() != 0 || ds_q[1].size() != 0) && t < TIMEOUT) begin
            @(negedge axis_clk);
            t++;
        end
        if (t == TIMEOUT) begin
            $display("downstream beats still missing after timeout");
            fail_cnt++;
        end
        for (int s = 0; s < 3; s++) begin
            if (exp_q[s].size() != 0) begin
                $display("source %0d has beats that never reached as_is", s);
                fail_cnt++;
            end
        end
        $display("done with %0d mismatches and %0d other errors", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end
endmodule

//--- build.f
+incdir+design
design/axis_beat_pkg.sv
design/axis_arb_pkg.sv
design/axis_beat_if.sv
design/upstream_arbiter.sv
design/downstream_fifo.sv
design/downstream_demux.sv
design/axis_switch.sv
bench/tb_clock_gen.sv
bench/axis_switch_sva.sv
bench/axis_switch_tb.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f build.f --top-module axis_switch_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module axis_switch_tb -Mdir obj_dir -o axis_switch_sim
	./obj_dir/axis_switch_sim | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
